/* include/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry shared by the packages and the RTL

// associativity
`define DC_WAYS 2

// sets per way
`define DC_SETS 16

// bytes held by one cache line
`define DC_LINE_BYTES 16

// byte address width seen by the core and by memory
`define DC_ADDR_W 32

`endif

/* list.f */
+incdir+include
source/dcache_types_pkg.sv
source/dcache_bus_pkg.sv
source/way_ram.sv
source/victim_lfsr.sv
source/store_merge.sv
source/lookup_pipe.sv
source/miss_ctrl.sv
source/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

/* run.sh */
#!/bin/sh
# compile the cache and its testbench with Verilator, then run the regression
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f list.f --top-module tb_dcache -o tb_dcache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

/* sim/dcache_cases.txt */
// op addr wstrb wdata expect; op 0 load, 1 load that must hit, 2 store, f ends the list
0 00001034 0 00000000 c0de1034
1 00001038 0 00000000 c0de1038
2 00001034 1 000000aa 00000000
2 00001038 c 12340000 00000000
2 0000103c f deadbeef 00000000
1 00001034 0 00000000 c0de10aa
1 00001038 0 00000000 12341038
1 0000103c 0 00000000 deadbeef
2 00002030 2 0000ee00 00000000
1 00002030 0 00000000 c0deee30
1 00002034 0 00000000 c0de2034
0 00003038 0 00000000 c0de3038
0 00001034 0 00000000 c0de10aa
0 00001038 0 00000000 12341038
0 0000103c 0 00000000 deadbeef
0 00002030 0 00000000 c0deee30
0 00003038 0 00000000 c0de3038
2 00005054 3 0000beef 00000000
1 00005054 0 00000000 c0debeef
1 00005050 0 00000000 c0de5050
f 00000000 0 00000000 00000000

/* sim/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_bus_pkg::mem_req_t mem_req_i,
    output dcache_bus_pkg::mem_rsp_t mem_rsp_o
);

    import dcache_types_pkg::*;
    import dcache_bus_pkg::*;

    // words written by the cache, keyed by word address
    logic [31:0] words_q [logic [29:0]];
    logic [31:0] lcg_state;
    logic        pending;
    int          wait_cnt;
    addr_t       read_addr;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // words never written hold their own address xor a fixed pattern
    function automatic logic [31:0] word_at(addr_t a);
        logic [29:0] key;
        key = a[31:2];
        if (words_q.exists(key)) begin
            return words_q[key];
        end
        return {key, 2'b00} ^ 32'hc0de0000;
    endfunction

    task automatic write_word(addr_t a, logic [31:0] data, logic [3:0] strb);
        logic [31:0] w;
        w = word_at(a);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        words_q[a[31:2]] = w;
    endtask

    // requests are taken at the falling edge, the response goes out
    // shortly after a rising edge
    initial begin
        mem_rsp_o = '0;
        lcg_state = 32'h15f3;
        pending = 1'b0;
        wait_cnt = 0;
        read_addr = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_i.valid) begin
                if (mem_req_i.we) begin
                    write_word(mem_req_i.addr, mem_req_i.wdata, mem_req_i.wstrb);
                end else begin
                    lcg_state = lcg_next(lcg_state);
                    // 2 to 5 cycles of read latency
                    wait_cnt = 1 + int'(lcg_state[17:16]);
                    read_addr = line_addr(mem_req_i.addr);
                    pending = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            mem_rsp_o = '0;
            if (pending) begin
                if (wait_cnt == 0) begin
                    mem_rsp_o.valid = 1'b1;
                    for (int i = 0; i < line_words; i++) begin
                        mem_rsp_o.data[i] = word_at(read_addr + addr_t'(i * 4));
                    end
                    pending = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

endmodule

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    import dcache_types_pkg::*;
    import dcache_bus_pkg::*;

    localparam int max_cases = 64;
    localparam int fields = 5;
    localparam int cycles_per_case = 40;

    // one outstanding core request and what its response must carry
    typedef struct packed {
        int          idx;
        int          op;
        logic [31:0] data;
        int          cycle;
    } expect_t;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    logic        ready;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [31:0] case_words [max_cases*fields];
    expect_t     rsp_q[$];
    mem_req_t    wr_q[$];
    int          num_cases;
    int          next_case;
    int          cycle_cnt;
    int          limit;
    logic        done;

    dcache_top dut (
        .clk(clk), .rst(rst), .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
        .ready_o(ready), .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    mem_model u_mem (.clk(clk), .rst(rst), .mem_req_i(mem_req), .mem_rsp_o(mem_rsp));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic string op_name(int op);
        case (op)
            0: return "load";
            1: return "hit load";
            default: return "store";
        endcase
    endfunction

    task automatic issue_case(input int k);
        int       op;
        expect_t  e;
        mem_req_t w;
        op = case_words[k*fields];
        cpu_req.valid = 1'b1;
        cpu_req.addr = case_words[k*fields+1];
        cpu_req.wstrb = case_words[k*fields+2][3:0];
        cpu_req.wdata = case_words[k*fields+3];
        e.idx = k;
        e.op = op;
        e.data = case_words[k*fields+4];
        e.cycle = cycle_cnt;
        rsp_q.push_back(e);
        // every store must show up as a write-through
        if (op == 2) begin
            w = '0;
            w.valid = 1'b1;
            w.we = 1'b1;
            w.addr = cpu_req.addr;
            w.wdata = cpu_req.wdata;
            w.wstrb = cpu_req.wstrb;
            wr_q.push_back(w);
        end
    endtask

    task automatic check_response();
        expect_t e;
        string   name;
        if (rsp_q.size() == 0) begin
            fail_run("the cache answered with no request outstanding");
        end else begin
            e = rsp_q.pop_front();
            name = $sformatf("case %0d %s", e.idx + 1, op_name(e.op));
            check_value(name, e.data, cpu_rsp.rdata);
            if (e.op == 1) begin
                check_value({name, " latency"}, 32'd1, cycle_cnt - e.cycle);
            end
        end
    endtask

    task automatic check_write();
        mem_req_t w;
        string    name;
        if (wr_q.size() == 0) begin
            fail_run("a memory write appeared with no store outstanding");
        end else begin
            w = wr_q.pop_front();
            name = $sformatf("write-through to %h", w.addr);
            check_value({name, " address"}, w.addr, mem_req.addr);
            check_value({name, " data"}, w.wdata, mem_req.wdata);
            check_value({name, " strobe"}, 32'(w.wstrb), 32'(mem_req.wstrb));
        end
    endtask

    initial begin
        cpu_req = '0;
        rst = 1'b1;
        cycle_cnt = 0;
        next_case = 0;
        num_cases = 0;
        done = 1'b0;
        $readmemh("sim/dcache_cases.txt", case_words);
        // op f marks the end of the list
        while (num_cases < max_cases && case_words[num_cases*fields] != 32'hf) begin
            num_cases++;
        end
        limit = num_cases * cycles_per_case;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        if (num_cases == 0 || num_cases == max_cases) begin
            fail_run("the case file could not be read or has no end marker");
        end else begin
            while (!done) begin
                @(posedge clk);
                #1;
                cycle_cnt++;
                if (cycle_cnt > limit) begin
                    fail_run("timeout, the cache stopped answering");
                end else begin
                    if (ready && next_case < num_cases) begin
                        issue_case(next_case);
                        next_case++;
                    end else begin
                        cpu_req = '0;
                    end
                    // outputs are settled by the falling edge
                    @(negedge clk);
                    if (cpu_rsp.valid) begin
                        check_response();
                    end
                    if (mem_req.valid && mem_req.we) begin
                        check_write();
                    end else if (mem_req.valid) begin
                        check_value("line read offset", 32'h0, mem_req.addr & 32'hf);
                    end
                    done = next_case == num_cases && rsp_q.size() == 0 && wr_q.size() == 0;
                end
            end
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* source/dcache_bus_pkg.sv */
package dcache_bus_pkg;

    import dcache_types_pkg::*;

    // a zero strobe in a core request is a load
    typedef struct packed {
        logic        valid;
        addr_t       addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } cpu_rsp_t;

    // memory reads always fetch the aligned line
    typedef struct packed {
        logic        valid;
        logic        we;
        addr_t       addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_rsp_t;

endpackage

/* source/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_bus_pkg::cpu_req_t cpu_req_i,
    output dcache_bus_pkg::cpu_rsp_t cpu_rsp_o,
    output logic                     ready_o,
    output dcache_bus_pkg::mem_req_t mem_req_o,
    input  dcache_bus_pkg::mem_rsp_t mem_rsp_i
);

    import dcache_types_pkg::*;
    import dcache_bus_pkg::*;

    index_t                     raddr;
    index_t                     waddr;
    tag_entry_t [`DC_WAYS-1:0]  tag_rdata;
    line_t [`DC_WAYS-1:0]       line_rdata;
    logic [`DC_WAYS-1:0]        tag_we;
    logic [`DC_WAYS-1:0]        line_we;
    tag_entry_t                 tag_wdata;
    cpu_req_t                   s2_req;
    logic                       hit;
    way_t                       hit_way;
    line_t                      hit_line;
    line_t                      merge_base;
    line_t                      merged_line;
    cpu_rsp_t                   hit_rsp;
    cpu_rsp_t                   miss_rsp;
    logic                       busy;
    logic                       base_sel;
    way_t                       victim;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        way_ram #(.entry_t(tag_entry_t), .reset_val('0)) u_tag_ram (
            .clk(clk), .rst(rst),
            .raddr_i(raddr), .rdata_o(tag_rdata[w]),
            .we_i(tag_we[w]), .waddr_i(waddr), .wdata_i(tag_wdata)
        );
        way_ram #(.entry_t(line_t), .reset_val('0)) u_line_ram (
            .clk(clk), .rst(rst),
            .raddr_i(raddr), .rdata_o(line_rdata[w]),
            .we_i(line_we[w]), .waddr_i(waddr), .wdata_i(merged_line)
        );
    end

    lookup_pipe u_lookup (
        .clk(clk), .rst(rst), .cpu_req_i(cpu_req_i), .busy_i(busy),
        .tag_rdata_i(tag_rdata), .line_rdata_i(line_rdata), .raddr_o(raddr),
        .s2_req_o(s2_req), .hit_o(hit), .hit_way_o(hit_way),
        .hit_line_o(hit_line), .hit_rsp_o(hit_rsp)
    );

    miss_ctrl u_miss (
        .clk(clk), .rst(rst), .s2_req_i(s2_req), .hit_i(hit), .hit_way_i(hit_way),
        .victim_i(victim), .mem_rsp_i(mem_rsp_i), .merged_i(merged_line),
        .busy_o(busy), .base_sel_o(base_sel), .tag_we_o(tag_we), .line_we_o(line_we),
        .waddr_o(waddr), .tag_wdata_o(tag_wdata), .miss_rsp_o(miss_rsp),
        .mem_req_o(mem_req_o)
    );

    // the merge base is the refill line during a miss and the hit line otherwise
    assign merge_base = base_sel ? mem_rsp_i.data : hit_line;

    store_merge u_merge (
        .base_i(merge_base), .word_i(addr_word(s2_req.addr)),
        .wstrb_i(s2_req.wstrb), .wdata_i(s2_req.wdata), .line_o(merged_line)
    );

    victim_lfsr u_lfsr (.clk(clk), .rst(rst), .victim_o(victim));

    assign ready_o = !busy;

    // hit and refill responses never coincide
    assign cpu_rsp_o.valid = hit_rsp.valid | miss_rsp.valid;
    assign cpu_rsp_o.rdata = hit_rsp.rdata | miss_rsp.rdata;

endmodule

/* source/dcache_types_pkg.sv */
`include "dcache_macros.svh"

package dcache_types_pkg;

    localparam int unsigned offset_w = $clog2(`DC_LINE_BYTES);
    localparam int unsigned index_w = $clog2(`DC_SETS);
    localparam int unsigned tag_w = `DC_ADDR_W - index_w - offset_w;
    localparam int unsigned line_words = `DC_LINE_BYTES / 4;
    localparam int unsigned word_w = $clog2(line_words);

    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0] tag_t;
    typedef logic [word_w-1:0] word_sel_t;
    typedef logic [line_words-1:0][31:0] line_t;
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // address field helpers
    function automatic index_t addr_index(addr_t addr);
        return addr[offset_w +: index_w];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`DC_ADDR_W-1 -: tag_w];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[2 +: word_w];
    endfunction

    // line aligned address for refill reads
    function automatic addr_t line_addr(addr_t addr);
        return {addr[`DC_ADDR_W-1:offset_w], {offset_w{1'b0}}};
    endfunction

endpackage

/* source/lookup_pipe.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module lookup_pipe (
    input  logic                                        clk,
    input  logic                                        rst,
    input  dcache_bus_pkg::cpu_req_t                    cpu_req_i,
    input  logic                                        busy_i,
    input  dcache_types_pkg::tag_entry_t [`DC_WAYS-1:0] tag_rdata_i,
    input  dcache_types_pkg::line_t [`DC_WAYS-1:0]      line_rdata_i,
    output dcache_types_pkg::index_t                    raddr_o,
    output dcache_bus_pkg::cpu_req_t                    s2_req_o,
    output logic                                        hit_o,
    output dcache_types_pkg::way_t                      hit_way_o,
    output dcache_types_pkg::line_t                     hit_line_o,
    output dcache_bus_pkg::cpu_rsp_t                    hit_rsp_o
);

    import dcache_types_pkg::*;
    import dcache_bus_pkg::*;

    cpu_req_t  s2_q;
    tag_t      s2_tag;
    word_sel_t s2_word;

    // stage one reads the arrays with the incoming index
    assign raddr_o = addr_index(cpu_req_i.addr);

    // stage two register
    // while busy the payload is kept for miss handling, but the valid
    // bit is consumed so the request is acted on only once
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_q.valid <= 1'b0;
        end else if (!busy_i) begin
            s2_q <= cpu_req_i;
        end else begin
            s2_q.valid <= 1'b0;
        end
    end

    assign s2_req_o = s2_q;
    assign s2_tag = addr_tag(s2_q.addr);
    assign s2_word = addr_word(s2_q.addr);

    // tag compare across the ways
    always_comb begin
        hit_o = 1'b0;
        hit_way_o = '0;
        hit_line_o = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (tag_rdata_i[w].valid && tag_rdata_i[w].tag == s2_tag) begin
                hit_o = 1'b1;
                hit_way_o = way_t'(w);
                hit_line_o = line_rdata_i[w];
            end
        end
    end

    // on a hit loads return the addressed word and stores
    // are acknowledged with zero data
    always_comb begin
        hit_rsp_o = '0;
        if (s2_q.valid && hit_o) begin
            hit_rsp_o.valid = 1'b1;
            if (s2_q.wstrb == 4'b0000) begin
                hit_rsp_o.rdata = hit_line_o[s2_word];
            end
        end
    end

endmodule

/* source/miss_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module miss_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  dcache_bus_pkg::cpu_req_t     s2_req_i,
    input  logic                         hit_i,
    input  dcache_types_pkg::way_t       hit_way_i,
    input  dcache_types_pkg::way_t       victim_i,
    input  dcache_bus_pkg::mem_rsp_t     mem_rsp_i,
    input  dcache_types_pkg::line_t      merged_i,
    output logic                         busy_o,
    output logic                         base_sel_o,
    output logic [`DC_WAYS-1:0]          tag_we_o,
    output logic [`DC_WAYS-1:0]          line_we_o,
    output dcache_types_pkg::index_t     waddr_o,
    output dcache_types_pkg::tag_entry_t tag_wdata_o,
    output dcache_bus_pkg::cpu_rsp_t     miss_rsp_o,
    output dcache_bus_pkg::mem_req_t     mem_req_o
);

    import dcache_types_pkg::*;
    import dcache_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait
    } state_e;

    state_e state_q;
    state_e state_d;
    way_t   victim_q;
    logic   s2_store;
    logic   store_hit;
    logic   start_miss;
    logic   refill_done;

    assign s2_store = s2_req_i.wstrb != 4'b0000;
    assign store_hit = state_q == st_idle && s2_req_i.valid && hit_i && s2_store;
    assign start_miss = state_q == st_idle && s2_req_i.valid && !hit_i;
    assign refill_done = state_q == st_wait && mem_rsp_i.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start_miss) begin
                    state_d = st_issue;
                end
            end
            // the read goes out for exactly one cycle
            st_issue: begin
                state_d = st_wait;
            end
            st_wait: begin
                if (mem_rsp_i.valid) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // victim is fixed when the miss is detected
    always_ff @(posedge clk) begin
        if (start_miss) begin
            victim_q <= victim_i;
        end
    end

    // a store hit costs one bubble and a miss stalls until the refill lands
    assign busy_o = store_hit || start_miss || state_q != st_idle;
    assign base_sel_o = state_q == st_wait;

    assign waddr_o = addr_index(s2_req_i.addr);
    assign tag_wdata_o = '{valid: 1'b1, tag: addr_tag(s2_req_i.addr)};

    always_comb begin
        tag_we_o = '0;
        line_we_o = '0;
        if (store_hit) begin
            line_we_o[hit_way_i] = 1'b1;
        end
        if (refill_done) begin
            tag_we_o[victim_q] = 1'b1;
            line_we_o[victim_q] = 1'b1;
        end
    end

    always_comb begin
        miss_rsp_o = '0;
        if (refill_done) begin
            miss_rsp_o.valid = 1'b1;
            if (!s2_store) begin
                miss_rsp_o.rdata = merged_i[addr_word(s2_req_i.addr)];
            end
        end
    end

    // line read in issue and write-through on a store hit or store refill
    always_comb begin
        mem_req_o = '0;
        if (state_q == st_issue) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr = line_addr(s2_req_i.addr);
        end else if (store_hit || (refill_done && s2_store)) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.we = 1'b1;
            mem_req_o.addr = s2_req_i.addr;
            mem_req_o.wdata = s2_req_i.wdata;
            mem_req_o.wstrb = s2_req_i.wstrb;
        end
    end

endmodule

/* source/store_merge.sv */
`timescale 1ns/1ps

module store_merge (
    input  dcache_types_pkg::line_t     base_i,
    input  dcache_types_pkg::word_sel_t word_i,
    input  logic [3:0]                  wstrb_i,
    input  logic [31:0]                 wdata_i,
    output dcache_types_pkg::line_t     line_o
);

    logic [31:0] word_old;
    logic [31:0] word_new;

    // pick the addressed word out of the base line
    assign word_old = base_i[word_i];

    // byte lanes under the strobe take the store data
    always_comb begin
        word_new = word_old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb_i[b]) begin
                word_new[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

    // put the word back, other words pass through
    // a load refill has a zero strobe and leaves the line as it was
    always_comb begin
        line_o = base_i;
        line_o[word_i] = word_new;
    end

endmodule

/* source/victim_lfsr.sv */
`timescale 1ns/1ps

module victim_lfsr (
    input  logic                   clk,
    input  logic                   rst,
    output dcache_types_pkg::way_t victim_o
);

    logic [15:0] lfsr_q;
    logic        feedback;

    // maximal length taps for x^16 + x^14 + x^13 + x^11 + 1
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    assign victim_o = lfsr_q[0];

endmodule

/* source/way_ram.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module way_ram #(
    parameter type entry_t = logic,
    parameter entry_t reset_val = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_types_pkg::index_t raddr_i,
    output entry_t                   rdata_o,
    input  logic                     we_i,
    input  dcache_types_pkg::index_t waddr_i,
    input  entry_t                   wdata_i
);

    entry_t mem_q [`DC_SETS];

    // read data is registered, so it lines up with the stage two request
    always_ff @(posedge clk) begin
        if (rst) begin
            // clearing every entry drops all tag valid bits
            for (int i = 0; i < `DC_SETS; i++) begin
                mem_q[i] <= reset_val;
            end
            rdata_o <= reset_val;
        end else begin
            if (we_i) begin
                mem_q[waddr_i] <= wdata_i;
            end
            // a same cycle write is not seen until the next read
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule
